/* lpbk_afu.f */
design/lpbk_pkg.sv
design/host_if_reg.sv
design/lpbk_csr.sv
design/lpbk_engine.sv
design/lpbk_afu.sv
design/lpbk_afu_top.sv
sim/clk_gen.sv
sim/lpbk_tb.sv

/* sim/lpbk_tb.sv */
`timescale 1ns/1ps

module lpbk_tb;

    localparam int ADDR_W = 32;
    localparam int DATA_W = lpbk_pkg::DATA_W;
    localparam int TAG_W  = lpbk_pkg::TAG_W;

    // DUT ports
    logic                pClk;
    logic                soft_reset;
    logic                rx_valid;
    lpbk_pkg::rx_kind_t  rx_kind;
    lpbk_pkg::rx_word_u  rx_word;
    logic                tx_almost_full;
    logic                rd_valid;
    logic [ADDR_W-1:0]   rd_addr;
    logic [TAG_W-1:0]    rd_tag;
    logic                wr_valid;
    logic [ADDR_W-1:0]   wr_addr;
    logic [DATA_W-1:0]   wr_data;

    // Shared random stream for delays, order and back-pressure
    integer seed = 32'h38205e4d;
    int     cyc;

    // Run state seen by the checker
    bit                checks_on;
    bit                run_active;
    bit                bp_en;
    logic [ADDR_W-1:0] exp_src;
    logic [ADDR_W-1:0] exp_dst;
    logic [ADDR_W-1:0] exp_dsm;
    int                exp_lines;
    bit                written [256];
    bit                read_seen [256];
    int                rsp_cyc [256];
    int                data_writes;
    bit                status_seen;
    logic [ADDR_W-1:0] wr_line;
    int                af_run;
    int                af_left;
    int                run_cyc;
    int                run_limit;

    // Host memory model, outstanding reads
    int                pend_tag [$];
    logic [ADDR_W-1:0] pend_addr [$];
    int                pend_ready [$];

    clk_gen clk_i (
        .pClk       (pClk),
        .soft_reset (soft_reset)
    );

    lpbk_afu_top #(
        .ADDR_W         (ADDR_W)
    ) dut_i (
        .pClk           (pClk),
        .soft_reset     (soft_reset),
        .rx_valid       (rx_valid),
        .rx_kind        (rx_kind),
        .rx_word        (rx_word),
        .tx_almost_full (tx_almost_full),
        .rd_valid       (rd_valid),
        .rd_addr        (rd_addr),
        .rd_tag         (rd_tag),
        .wr_valid       (wr_valid),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    // ==================================================
    // Reference model
    // ==================================================

    // Source memory content, mixes every address bit
    function automatic logic [DATA_W-1:0] src_data(input logic [ADDR_W-1:0] addr);
        logic [31:0] mix;
        mix = (addr * 32'h9e3779b9) ^ {addr[15:0], addr[31:16]};
        return {addr ^ 32'h5a5ac3c3, mix};
    endfunction

    // Done flag on top, line count at the bottom
    function automatic logic [DATA_W-1:0] status_word(input int lines);
        logic [DATA_W-1:0] w;
        w              = '0;
        w[DATA_W-1]    = 1'b1;
        w[TAG_W-1:0]   = lines[TAG_W-1:0];
        return w;
    endfunction

    task automatic check_values(input logic [63:0] actual, input logic [63:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("ERR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // ==================================================
    // Host side stimulus
    // ==================================================

    // One host cycle: back-pressure update and at most one read response
    task automatic tick();
        int ready_idx [$];
        int pick;
        int i;
        @(posedge pClk);
        #1;
        rx_valid = 1'b0;
        if (!bp_en) begin
            tx_almost_full = 1'b0;
        end else if (af_left > 0) begin
            af_left--;
            if (af_left == 0) begin
                tx_almost_full = 1'b0;
            end
        end else if (($random(seed) & 7) == 0) begin
            // Burst of 2 to 9 cycles
            tx_almost_full = 1'b1;
            af_left        = 2 + ($unsigned($random(seed)) % 8);
        end
        for (i = 0; i < pend_tag.size(); i++) begin
            if (pend_ready[i] <= cyc) begin
                ready_idx.push_back(i);
            end
        end
        // Any ready read may answer first
        if (ready_idx.size() > 0) begin
            pick                = ready_idx[$unsigned($random(seed)) % ready_idx.size()];
            rx_valid            = 1'b1;
            rx_kind             = lpbk_pkg::RX_RD_RSP;
            rx_word.rsp.tag     = pend_tag[pick];
            rx_word.rsp.data    = src_data(pend_addr[pick]);
            rsp_cyc[pend_tag[pick]] = cyc;
            pend_tag.delete(pick);
            pend_addr.delete(pick);
            pend_ready.delete(pick);
        end
    endtask

    // MMIO write, takes the receive port for one cycle
    task automatic csr_write(input logic [15:0] offset, input logic [63:0] value);
        @(posedge pClk);
        #1;
        rx_valid             = 1'b1;
        rx_kind              = lpbk_pkg::RX_MMIO_WR;
        rx_word.mmio.offset  = offset;
        rx_word.mmio.value   = value;
    endtask

    // Configure, start, wait for the status line, then watch a quiet tail
    task automatic run_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                            input logic [ADDR_W-1:0] dsm, input int lines,
                            input bit use_bp, input bit restart);
        int k;
        int n;
        exp_src   = src;
        exp_dst   = dst;
        exp_dsm   = dsm;
        exp_lines = lines;
        for (k = 0; k < 256; k++) begin
            written[k]   = 1'b0;
            read_seen[k] = 1'b0;
        end
        data_writes = 0;
        status_seen = 1'b0;
        bp_en       = use_bp;
        af_left     = 0;
        run_limit   = 40 * lines + 200;
        run_cyc     = 0;
        run_active  = 1'b1;
        csr_write(lpbk_pkg::CSR_DSM_BASE, 64'(dsm));
        csr_write(lpbk_pkg::CSR_SRC_ADDR, 64'(src));
        csr_write(lpbk_pkg::CSR_DST_ADDR, 64'(dst));
        csr_write(lpbk_pkg::CSR_NUM_LINES, 64'(lines));
        csr_write(lpbk_pkg::CSR_CTL, 64'h1);
        n = 0;
        while (!status_seen) begin
            tick();
            n++;
            // Start again mid-copy, engine is busy
            if (restart && n == 6) begin
                csr_write(lpbk_pkg::CSR_CTL, 64'h1);
            end
        end
        bp_en = 1'b0;
        // A second status write or a stray read would land here
        repeat (20) tick();
        check_values(data_writes, lines, "data write count");
        check_values(pend_tag.size(), 0, "reads never answered");
        run_active = 1'b0;
    endtask

    // ==================================================
    // Checker and timeout
    // ==================================================

    always @(posedge pClk) begin
        cyc <= cyc + 1;
    end

    // Outputs are sampled mid-cycle
    always @(negedge pClk) begin
        if (checks_on) begin
            af_run = tx_almost_full ? af_run + 1 : 0;
            if (!run_active) begin
                check_values(rd_valid, 0, "read request while idle");
                check_values(wr_valid, 0, "write request while idle");
            end
            if (rd_valid) begin
                check_values(status_seen, 0, "read after status write");
                check_values(rd_tag < exp_lines, 1, "read outside source range");
                check_values(read_seen[rd_tag], 0, "line read twice");
                check_values(rd_addr, exp_src + rd_tag, "read address");
                // Three reads of slack after almost-full rises
                check_values(af_run > 3, 0, "read beyond almost-full slack");
                read_seen[rd_tag] = 1'b1;
                pend_tag.push_back(rd_tag);
                pend_addr.push_back(rd_addr);
                pend_ready.push_back(cyc + 1 + ($unsigned($random(seed)) % 8));
            end
            // DSM line and destination lines never overlap
            if (wr_valid && wr_addr == exp_dsm) begin
                check_values(status_seen, 0, "second status write");
                check_values(data_writes, exp_lines, "status before all data writes");
                check_values(wr_data, status_word(exp_lines), "status data");
                status_seen = 1'b1;
            end else if (wr_valid) begin
                check_values(status_seen, 0, "data write after status write");
                wr_line = wr_addr - exp_dst;
                check_values(wr_line < exp_lines, 1, "write outside destination");
                check_values(written[wr_line], 0, "line written twice");
                check_values(wr_data, src_data(exp_src + wr_line), "copied data");
                check_values(cyc, rsp_cyc[wr_line] + 3, "response to write latency");
                written[wr_line] = 1'b1;
                data_writes++;
            end
        end
    end

    always @(posedge pClk) begin
        if (run_active) begin
            run_cyc = run_cyc + 1;
            if (run_cyc > run_limit) begin
                $display("Copy of %0d lines never finished within %0d cycles",
                         exp_lines, run_limit);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        rx_valid       = 1'b0;
        rx_kind        = lpbk_pkg::RX_MMIO_WR;
        rx_word        = '0;
        tx_almost_full = 1'b0;
        checks_on      = 1'b0;
        run_active     = 1'b0;
        bp_en          = 1'b0;
        af_run         = 0;
        exp_lines      = 0;
        wait (soft_reset === 1'b0);
        // Registered reset still high for one more edge
        repeat (2) tick();
        checks_on = 1'b1;
        // Idle after reset, no CSR traffic
        repeat (10) tick();
        run_copy(32'h0000_1000, 32'h0000_8000, 32'h0000_0040, 16, 1'b0, 1'b0);
        run_copy(32'h0000_2000, 32'h0000_9000, 32'h0000_0048, 16, 1'b1, 1'b0);
        run_copy(32'h0000_3000, 32'h0000_a000, 32'h0000_0050, 16, 1'b0, 1'b1);
        // Fresh bases after a completed run
        run_copy(32'h0004_4400, 32'h000b_8800, 32'h0000_0058, 12, 1'b1, 1'b0);
        repeat (10) tick();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 5
) (
    output logic pClk,
    output logic soft_reset
);

    // Free running host clock
    initial begin
        pClk = 1'b0;
        forever #(PERIOD / 2) pClk = ~pClk;
    end

    // Soft reset held for RST_CYCLES rising edges, released just after the last
    initial begin
        soft_reset = 1'b1;
        repeat (RST_CYCLES) @(posedge pClk);
        #1;
        soft_reset = 1'b0;
    end

endmodule

/* design/lpbk_afu_top.sv */
`timescale 1ns/1ps

module lpbk_afu_top #(
    parameter int ADDR_W = 32
) (
    // Host clock and soft reset, active high
    input  logic                          pClk,
    input  logic                          soft_reset,

    // Host receive side
    input  logic                          rx_valid,
    input  lpbk_pkg::rx_kind_t            rx_kind,
    input  lpbk_pkg::rx_word_u            rx_word,
    input  logic                          tx_almost_full,

    // Read requests
    output logic                          rd_valid,
    output logic [ADDR_W-1:0]             rd_addr,
    output logic [lpbk_pkg::TAG_W-1:0]    rd_tag,

    // Write requests, data lines and DSM status
    output logic                          wr_valid,
    output logic [ADDR_W-1:0]             wr_addr,
    output logic [lpbk_pkg::DATA_W-1:0]   wr_data
);

    // ==================================================
    // Boundary stage, both directions
    // ==================================================

    // Registered host inputs
    logic                          soft_reset_q;
    logic                          rx_valid_q;
    lpbk_pkg::rx_kind_t            rx_kind_q;
    lpbk_pkg::rx_word_u            rx_word_q;
    logic                          tx_almost_full_q;

    // AFU requests before the output flops
    logic                          rd_valid_d;
    logic [ADDR_W-1:0]             rd_addr_d;
    logic [lpbk_pkg::TAG_W-1:0]    rd_tag_d;
    logic                          wr_valid_d;
    logic [ADDR_W-1:0]             wr_addr_d;
    logic [lpbk_pkg::DATA_W-1:0]   wr_data_d;

    host_if_reg #(
        .ADDR_W           (ADDR_W)
    ) if_reg_i (
        .pClk             (pClk),
        .soft_reset       (soft_reset),
        .rx_valid         (rx_valid),
        .rx_kind          (rx_kind),
        .rx_word          (rx_word),
        .tx_almost_full   (tx_almost_full),
        .soft_reset_q     (soft_reset_q),
        .rx_valid_q       (rx_valid_q),
        .rx_kind_q        (rx_kind_q),
        .rx_word_q        (rx_word_q),
        .tx_almost_full_q (tx_almost_full_q),
        .rd_valid_d       (rd_valid_d),
        .rd_addr_d        (rd_addr_d),
        .rd_tag_d         (rd_tag_d),
        .wr_valid_d       (wr_valid_d),
        .wr_addr_d        (wr_addr_d),
        .wr_data_d        (wr_data_d),
        .rd_valid         (rd_valid),
        .rd_addr          (rd_addr),
        .rd_tag           (rd_tag),
        .wr_valid         (wr_valid),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data)
    );

    // ==================================================
    // Copy AFU, reset by the registered soft reset
    // ==================================================

    lpbk_afu #(
        .ADDR_W         (ADDR_W)
    ) afu_i (
        .pClk           (pClk),
        .rst            (soft_reset_q),
        .rx_valid       (rx_valid_q),
        .rx_kind        (rx_kind_q),
        .rx_word        (rx_word_q),
        .tx_almost_full (tx_almost_full_q),
        .rd_valid_d     (rd_valid_d),
        .rd_addr_d      (rd_addr_d),
        .rd_tag_d       (rd_tag_d),
        .wr_valid_d     (wr_valid_d),
        .wr_addr_d      (wr_addr_d),
        .wr_data_d      (wr_data_d)
    );

endmodule

/* design/lpbk_afu.sv */
`timescale 1ns/1ps

module lpbk_afu #(
    parameter int ADDR_W = 32
) (
    input  logic                          pClk,
    input  logic                          rst,

    // Registered host receive side
    input  logic                          rx_valid,
    input  lpbk_pkg::rx_kind_t            rx_kind,
    input  lpbk_pkg::rx_word_u            rx_word,
    input  logic                          tx_almost_full,

    // Requests toward the boundary register
    output logic                          rd_valid_d,
    output logic [ADDR_W-1:0]             rd_addr_d,
    output logic [lpbk_pkg::TAG_W-1:0]    rd_tag_d,
    output logic                          wr_valid_d,
    output logic [ADDR_W-1:0]             wr_addr_d,
    output logic [lpbk_pkg::DATA_W-1:0]   wr_data_d
);

    // Receive split by kind
    logic                       csr_wr;
    logic                       rsp_valid;

    // CSR block to engine
    logic [ADDR_W-1:0]          src_base;
    logic [ADDR_W-1:0]          dst_base;
    logic [ADDR_W-1:0]          dsm_addr;
    logic [lpbk_pkg::TAG_W-1:0] num_lines;
    logic                       start;
    logic                       busy;

    // One strobe per consumer, same word seen through its own view
    always_comb begin
        csr_wr    = rx_valid && (rx_kind == lpbk_pkg::RX_MMIO_WR);
        rsp_valid = rx_valid && (rx_kind == lpbk_pkg::RX_RD_RSP);
    end

    lpbk_csr #(
        .ADDR_W     (ADDR_W)
    ) csr_i (
        .pClk       (pClk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .csr_offset (rx_word.mmio.offset),
        .csr_value  (rx_word.mmio.value),
        .busy       (busy),
        .src_base   (src_base),
        .dst_base   (dst_base),
        .dsm_addr   (dsm_addr),
        .num_lines  (num_lines),
        .start      (start)
    );

    lpbk_engine #(
        .ADDR_W         (ADDR_W)
    ) engine_i (
        .pClk           (pClk),
        .rst            (rst),
        .start          (start),
        .src_base       (src_base),
        .dst_base       (dst_base),
        .dsm_addr       (dsm_addr),
        .num_lines      (num_lines),
        .tx_almost_full (tx_almost_full),
        .rsp_valid      (rsp_valid),
        .rsp_tag        (rx_word.rsp.tag),
        .rsp_data       (rx_word.rsp.data),
        .busy           (busy),
        .rd_valid       (rd_valid_d),
        .rd_addr        (rd_addr_d),
        .rd_tag         (rd_tag_d),
        .wr_valid       (wr_valid_d),
        .wr_addr        (wr_addr_d),
        .wr_data        (wr_data_d)
    );

endmodule

/* design/lpbk_engine.sv */
`timescale 1ns/1ps

module lpbk_engine #(
    parameter int ADDR_W = 32
) (
    input  logic                          pClk,
    input  logic                          rst,

    // Configuration and launch
    input  logic                          start,
    input  logic [ADDR_W-1:0]             src_base,
    input  logic [ADDR_W-1:0]             dst_base,
    input  logic [ADDR_W-1:0]             dsm_addr,
    input  logic [lpbk_pkg::TAG_W-1:0]    num_lines,

    // Host flow control and read responses
    input  logic                          tx_almost_full,
    input  logic                          rsp_valid,
    input  logic [lpbk_pkg::TAG_W-1:0]    rsp_tag,
    input  logic [lpbk_pkg::DATA_W-1:0]   rsp_data,

    // Status and requests
    output logic                          busy,
    output logic                          rd_valid,
    output logic [ADDR_W-1:0]             rd_addr,
    output logic [lpbk_pkg::TAG_W-1:0]    rd_tag,
    output logic                          wr_valid,
    output logic [ADDR_W-1:0]             wr_addr,
    output logic [lpbk_pkg::DATA_W-1:0]   wr_data
);

    // Run configuration, latched at launch
    logic [ADDR_W-1:0]          src_q;
    logic [ADDR_W-1:0]          dst_q;
    logic [ADDR_W-1:0]          dsm_q;
    logic [lpbk_pkg::TAG_W-1:0] lines_q;

    // Next line to read and completed data writes
    logic [lpbk_pkg::TAG_W-1:0] rd_idx;
    logic [lpbk_pkg::TAG_W-1:0] wr_cnt;

    // Launch cycle bypass of the latched values
    logic                       launch;
    logic [ADDR_W-1:0]          cur_src;
    logic [lpbk_pkg::TAG_W-1:0] cur_lines;
    logic [lpbk_pkg::TAG_W-1:0] cur_idx;
    logic                       issue;
    logic                       all_done;

    // ==================================================
    // Issue and completion decisions
    // ==================================================

    always_comb begin
        launch    = start && !busy;
        // First read leaves in the launch cycle itself
        cur_src   = launch ? src_base : src_q;
        cur_lines = launch ? num_lines : lines_q;
        cur_idx   = launch ? '0 : rd_idx;
        // One read per cycle, paused by almost-full
        issue     = (launch || busy) && !tx_almost_full && (cur_idx < cur_lines);
        // Every data write out, status write next
        all_done  = busy && (wr_cnt == lines_q);
    end

    always_ff @(posedge pClk) begin
        if (launch) begin
            src_q   <= src_base;
            dst_q   <= dst_base;
            dsm_q   <= dsm_addr;
            lines_q <= num_lines;
        end
    end

    // ==================================================
    // Run control
    // ==================================================

    always_ff @(posedge pClk) begin
        if (rst) begin
            busy   <= 1'b0;
            rd_idx <= '0;
            wr_cnt <= '0;
        end else begin
            // Busy ends with the status write
            if (launch) begin
                busy <= 1'b1;
            end else if (all_done) begin
                busy <= 1'b0;
            end
            if (issue) begin
                rd_idx <= cur_idx + 1'b1;
            end else if (launch) begin
                rd_idx <= '0;
            end
            // Responses complete in any order, only their number matters
            if (launch) begin
                wr_cnt <= '0;
            end else if (rsp_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Request outputs
    // ==================================================

    always_ff @(posedge pClk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            rd_valid <= issue;
            // No response can be pending once all_done is seen
            wr_valid <= rsp_valid || all_done;
        end
    end

    always_ff @(posedge pClk) begin
        // Tag is the line index
        rd_addr <= cur_src + ADDR_W'(cur_idx);
        rd_tag  <= cur_idx;
        if (all_done) begin
            // DSM line, done flag in the top bit
            wr_addr <= dsm_q;
            wr_data <= {1'b1, {(lpbk_pkg::DATA_W - lpbk_pkg::TAG_W - 1){1'b0}}, lines_q};
        end else begin
            wr_addr <= dst_q + ADDR_W'(rsp_tag);
            wr_data <= rsp_data;
        end
    end

endmodule

/* design/lpbk_csr.sv */
`timescale 1ns/1ps

module lpbk_csr #(
    parameter int ADDR_W = 32
) (
    input  logic                            pClk,
    input  logic                            rst,

    // Decoded MMIO write from the AFU body
    input  logic                            csr_wr,
    input  logic [lpbk_pkg::CSR_OFF_W-1:0]  csr_offset,
    input  logic [lpbk_pkg::DATA_W-1:0]     csr_value,

    // Engine status
    input  logic                            busy,

    // Copy configuration
    output logic [ADDR_W-1:0]               src_base,
    output logic [ADDR_W-1:0]               dst_base,
    output logic [ADDR_W-1:0]               dsm_addr,
    output logic [lpbk_pkg::TAG_W-1:0]      num_lines,
    output logic                            start
);

    // Per-register write hits
    logic hit_dsm;
    logic hit_src;
    logic hit_dst;
    logic hit_lines;
    logic hit_ctl;

    // ==================================================
    // Offset decode
    // ==================================================

    always_comb begin
        hit_dsm   = csr_wr && (csr_offset == lpbk_pkg::CSR_DSM_BASE);
        hit_src   = csr_wr && (csr_offset == lpbk_pkg::CSR_SRC_ADDR);
        hit_dst   = csr_wr && (csr_offset == lpbk_pkg::CSR_DST_ADDR);
        hit_lines = csr_wr && (csr_offset == lpbk_pkg::CSR_NUM_LINES);
        hit_ctl   = csr_wr && (csr_offset == lpbk_pkg::CSR_CTL);
    end

    // ==================================================
    // Configuration registers
    // ==================================================

    always_ff @(posedge pClk) begin
        if (rst) begin
            src_base  <= '0;
            dst_base  <= '0;
            dsm_addr  <= '0;
            num_lines <= '0;
        end else begin
            // Addresses are line addresses, low bits of the value
            if (hit_dsm) begin
                dsm_addr <= csr_value[ADDR_W-1:0];
            end
            if (hit_src) begin
                src_base <= csr_value[ADDR_W-1:0];
            end
            if (hit_dst) begin
                dst_base <= csr_value[ADDR_W-1:0];
            end
            if (hit_lines) begin
                num_lines <= csr_value[lpbk_pkg::TAG_W-1:0];
            end
        end
    end

    // Start pulse, one cycle, dropped while a copy runs
    // Back-to-back CTL writes also blocked by the pulse itself,
    // busy only rises one cycle after start
    always_ff @(posedge pClk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= hit_ctl && csr_value[0] && !busy && !start;
        end
    end

endmodule

/* design/host_if_reg.sv */
`timescale 1ns/1ps

module host_if_reg #(
    parameter int ADDR_W = 32
) (
    input  logic                          pClk,

    // Host to AFU, raw and registered
    input  logic                          soft_reset,
    input  logic                          rx_valid,
    input  lpbk_pkg::rx_kind_t            rx_kind,
    input  lpbk_pkg::rx_word_u            rx_word,
    input  logic                          tx_almost_full,
    output logic                          soft_reset_q,
    output logic                          rx_valid_q,
    output lpbk_pkg::rx_kind_t            rx_kind_q,
    output lpbk_pkg::rx_word_u            rx_word_q,
    output logic                          tx_almost_full_q,

    // AFU to host, from the AFU and toward the host
    input  logic                          rd_valid_d,
    input  logic [ADDR_W-1:0]             rd_addr_d,
    input  logic [lpbk_pkg::TAG_W-1:0]    rd_tag_d,
    input  logic                          wr_valid_d,
    input  logic [ADDR_W-1:0]             wr_addr_d,
    input  logic [lpbk_pkg::DATA_W-1:0]   wr_data_d,
    output logic                          rd_valid,
    output logic [ADDR_W-1:0]             rd_addr,
    output logic [lpbk_pkg::TAG_W-1:0]    rd_tag,
    output logic                          wr_valid,
    output logic [ADDR_W-1:0]             wr_addr,
    output logic [lpbk_pkg::DATA_W-1:0]   wr_data
);

    // ==================================================
    // Receive direction
    // ==================================================

    // Soft reset itself takes one flop like every other input
    always_ff @(posedge pClk) begin
        soft_reset_q     <= soft_reset;
        tx_almost_full_q <= tx_almost_full;
        rx_kind_q        <= rx_kind;
        rx_word_q        <= rx_word;
        // Strobes held off while the AFU is in reset
        rx_valid_q       <= rx_valid && !soft_reset_q;
    end

    // ==================================================
    // Transmit direction
    // ==================================================

    always_ff @(posedge pClk) begin
        rd_addr  <= rd_addr_d;
        rd_tag   <= rd_tag_d;
        wr_addr  <= wr_addr_d;
        wr_data  <= wr_data_d;
        // Host sees no requests during reset
        rd_valid <= rd_valid_d && !soft_reset_q;
        wr_valid <= wr_valid_d && !soft_reset_q;
    end

endmodule

/* design/lpbk_pkg.sv */
package lpbk_pkg;

    // ==================================================
    // Host word widths
    // ==================================================

    // One cache line payload, reduced model
    localparam int DATA_W = 64;
    // Request tag, carries the line index of a copy
    localparam int TAG_W = 16;
    // MMIO offset field of a CSR write
    localparam int CSR_OFF_W = 16;
    // Full receive word, tag or offset above the data
    localparam int RX_W = DATA_W + TAG_W;

    // ==================================================
    // Receive word and its two decodings
    // ==================================================

    // Kind of a receive word
    typedef enum logic [0:0] {
        RX_MMIO_WR = 1'b0,
        RX_RD_RSP  = 1'b1
    } rx_kind_t;

    // CSR write view
    typedef struct packed {
        logic [CSR_OFF_W-1:0] offset;
        logic [DATA_W-1:0]    value;
    } rx_mmio_t;

    // Read response view
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } rx_rsp_t;

    // Same RX_W bits, decoded by rx_kind_t
    typedef union packed {
        rx_mmio_t mmio;
        rx_rsp_t  rsp;
    } rx_word_u;

    // ==================================================
    // CSR offsets
    // ==================================================

    localparam logic [CSR_OFF_W-1:0] CSR_DSM_BASE  = 16'h0010;
    localparam logic [CSR_OFF_W-1:0] CSR_SRC_ADDR  = 16'h0020;
    localparam logic [CSR_OFF_W-1:0] CSR_DST_ADDR  = 16'h0028;
    // Line count sits in the low TAG_W bits
    localparam logic [CSR_OFF_W-1:0] CSR_NUM_LINES = 16'h0030;
    // Bit 0 of the value starts a copy
    localparam logic [CSR_OFF_W-1:0] CSR_CTL       = 16'h0038;

endpackage
